//--- rtl/revo_pkg.sv
package revo_pkg;

	typedef logic [15:0] revo_length_t; // Bunch slots per revolution
	typedef logic [7:0]  divide_t;      // Clock cycles per bunch slot
	typedef logic [15:0] revo_count_t;
	typedef logic [1:0]  cfg_addr_t;
	typedef logic [15:0] cfg_data_t;

	localparam cfg_addr_t ADDR_LENGTH  = 2'd0;
	localparam cfg_addr_t ADDR_DIVIDE  = 2'd1;
	localparam cfg_addr_t ADDR_CONTROL = 2'd2;
	localparam cfg_addr_t ADDR_STATUS  = 2'd3; // Read only

	// Bit positions in the control and status words
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT  = 1;
	localparam int STAT_ERROR_BIT  = 0;
	localparam int STAT_LOCKED_BIT = 1;

	typedef enum logic [1:0] {
		SEARCH,
		FIRST,
		TRACK
	} decoder_state_t;

endpackage

//--- rtl/revo_config_regs.sv
`timescale 1ns/1ps

module revo_config_regs import revo_pkg::*; #(
	parameter revo_length_t DEFAULT_REVO_LENGTH = 16'd12,
	parameter divide_t      DEFAULT_DIVIDE      = 8'd4
) (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         cfg_write,
	input  cfg_addr_t    cfg_addr,
	input  cfg_data_t    cfg_data,
	input  logic         period_error,
	input  logic         locked,
	output cfg_data_t    cfg_rdata,
	output revo_length_t revo_length,
	output divide_t      divide,
	output logic         enable,
	output logic         clear
);

	revo_length_t length_wr;
	divide_t      divide_wr;

	// Anything below 2 cannot form a carrier or a revolution
	assign length_wr = (cfg_data < 16'd2) ? 16'd2 : cfg_data;
	assign divide_wr = (cfg_data[7:0] < 8'd2) ? 8'd2 : cfg_data[7:0];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			revo_length <= DEFAULT_REVO_LENGTH;
			divide      <= DEFAULT_DIVIDE;
			enable      <= 1'b0;
			clear       <= 1'b0;
		end else begin
			clear <= 1'b0; // Single cycle pulse
			if (cfg_write) begin
				case (cfg_addr)
					ADDR_LENGTH: revo_length <= length_wr;
					ADDR_DIVIDE: divide <= divide_wr;
					ADDR_CONTROL: begin
						enable <= cfg_data[CTRL_ENABLE_BIT];
						clear  <= cfg_data[CTRL_CLEAR_BIT];
					end
					default: ; // Status ignores writes
				endcase
			end
		end
	end

	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			ADDR_LENGTH:  cfg_rdata = revo_length;
			ADDR_DIVIDE:  cfg_rdata = cfg_data_t'(divide);
			ADDR_CONTROL: cfg_rdata[CTRL_ENABLE_BIT] = enable; // Clear reads back as 0
			ADDR_STATUS: begin
				cfg_rdata[STAT_ERROR_BIT]  = period_error;
				cfg_rdata[STAT_LOCKED_BIT] = locked;
			end
			default: cfg_rdata = '0;
		endcase
	end

endmodule

//--- rtl/revo_generator.sv
`timescale 1ns/1ps

module revo_generator import revo_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         enable,
	input  revo_length_t revo_length,
	input  divide_t      divide,
	output logic         bunch_strobe,
	output logic         revo_marker
);

	divide_t      div_count;
	revo_length_t slot_index;
	logic         slot_end;
	logic         revo_end;

	// Greater-or-equal so a smaller value written mid-run still wraps
	assign slot_end = (div_count >= divide - 8'd1);
	assign revo_end = (slot_index >= revo_length - 16'd1);

	// Divider counter restarts from 0 whenever enable drops
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			div_count <= '0;
		end else if (!enable) begin
			div_count <= '0;
		end else if (slot_end) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 8'd1;
		end
	end

	// Slot index advances on the last cycle of each slot
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			slot_index <= '0;
		end else if (!enable) begin
			slot_index <= '0;
		end else if (slot_end) begin
			if (revo_end)
				slot_index <= '0;
			else
				slot_index <= slot_index + 16'd1;
		end
	end

	// Strobe marks the first cycle of every slot
	assign bunch_strobe = enable && (div_count == '0);
	assign revo_marker  = enable && (slot_index == '0); // Whole of slot 0

endmodule

//--- rtl/revo_encoder.sv
`timescale 1ns/1ps

module revo_encoder (
	input  logic clock,
	input  logic rst_n,
	input  logic bunch_strobe,
	input  logic revo_marker,
	output logic line_clk,
	output logic line_trg
);

	logic carrier_next;

	assign carrier_next = ~line_clk;

	// Carrier toggles once per bunch slot
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			line_clk <= 1'b0;
		end else if (bunch_strobe) begin
			line_clk <= carrier_next;
		end
	end

	// Trigger is the carrier with the marker folded in by XOR.
	// Loading it on the same strobe keeps both lines aligned, so the
	// receiver sees a clean marker with no single-cycle glitch.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			line_trg <= 1'b0;
		end else if (bunch_strobe) begin
			line_trg <= carrier_next ^ revo_marker;
		end
	end

endmodule

//--- rtl/revo_decoder.sv
`timescale 1ns/1ps

module revo_decoder import revo_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         clear,
	input  logic         line_clk_in,
	input  logic         line_trg_in,
	input  revo_length_t revo_length,
	output logic         revo_detect,
	output revo_count_t  revo_count,
	output revo_length_t last_period,
	output logic         period_error,
	output logic         locked
);

	decoder_state_t state;
	logic           clk_q, clk_qq;
	logic           trg_q;
	logic           marker_q;
	logic           marker;
	logic           mark_rise;
	logic           slot_edge;
	revo_length_t   slot_count;

	// Input stage
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			clk_q  <= 1'b0;
			clk_qq <= 1'b0;
			trg_q  <= 1'b0;
		end else begin
			clk_q  <= line_clk_in;
			clk_qq <= clk_q;
			trg_q  <= line_trg_in;
		end
	end

	assign marker    = clk_q ^ trg_q; // Recovered revolution marker
	assign mark_rise = marker & ~marker_q;
	assign slot_edge = clk_q ^ clk_qq; // One carrier transition per slot
	assign locked    = (state == TRACK);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state        <= SEARCH;
			marker_q     <= 1'b0;
			revo_detect  <= 1'b0;
			revo_count   <= '0;
			last_period  <= '0;
			slot_count   <= '0;
			period_error <= 1'b0;
		end else if (clear) begin
			state        <= SEARCH;
			marker_q     <= marker;
			revo_detect  <= 1'b0;
			revo_count   <= '0;
			last_period  <= '0;
			slot_count   <= '0;
			period_error <= 1'b0;
		end else begin
			marker_q    <= marker;
			revo_detect <= mark_rise;
			if (mark_rise) begin
				// The mark's own transition opens the next period
				slot_count  <= 16'd1;
				last_period <= slot_count;
				revo_count  <= revo_count + 16'd1;
				case (state)
					SEARCH: state <= FIRST;
					FIRST:  state <= TRACK; // Period since the first mark is not judged
					TRACK: begin
						if (slot_count != revo_length)
							period_error <= 1'b1; // Sticky until clear
					end
					default: state <= SEARCH;
				endcase
			end else if (slot_edge) begin
				slot_count <= slot_count + 16'd1;
			end
		end
	end

endmodule

//--- rtl/revo_timing_top.sv
`timescale 1ns/1ps

module revo_timing_top import revo_pkg::*; #(
	parameter revo_length_t DEFAULT_REVO_LENGTH = 16'd12,
	parameter divide_t      DEFAULT_DIVIDE      = 8'd4
) (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         cfg_write,
	input  cfg_addr_t    cfg_addr,
	input  cfg_data_t    cfg_data,
	output cfg_data_t    cfg_rdata,
	output logic         line_clk,
	output logic         line_trg,
	input  logic         line_clk_in,
	input  logic         line_trg_in,
	output logic         revo_detect,
	output revo_count_t  revo_count,
	output revo_length_t last_period
);

	revo_length_t revo_length;
	divide_t      divide;
	logic         enable;
	logic         clear;
	logic         period_error;
	logic         locked;
	logic         bunch_strobe;
	logic         revo_marker;

	revo_config_regs #(
		.DEFAULT_REVO_LENGTH(DEFAULT_REVO_LENGTH),
		.DEFAULT_DIVIDE(DEFAULT_DIVIDE)
	) i_revo_config_regs (
		.clock(clock), .rst_n(rst_n),
		.cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.period_error(period_error), .locked(locked),
		.cfg_rdata(cfg_rdata),
		.revo_length(revo_length), .divide(divide),
		.enable(enable), .clear(clear)
	);

	revo_generator i_revo_generator (
		.clock(clock), .rst_n(rst_n), .enable(enable),
		.revo_length(revo_length), .divide(divide),
		.bunch_strobe(bunch_strobe), .revo_marker(revo_marker)
	);

	// Outgoing pair in the same scheme as clk78 and trg36
	revo_encoder i_revo_encoder (
		.clock(clock), .rst_n(rst_n),
		.bunch_strobe(bunch_strobe), .revo_marker(revo_marker),
		.line_clk(line_clk), .line_trg(line_trg)
	);

	revo_decoder i_revo_decoder (
		.clock(clock), .rst_n(rst_n), .clear(clear),
		.line_clk_in(line_clk_in), .line_trg_in(line_trg_in),
		.revo_length(revo_length),
		.revo_detect(revo_detect), .revo_count(revo_count),
		.last_period(last_period),
		.period_error(period_error), .locked(locked)
	);

endmodule

//--- tb/revo_timing_checker.sv
`timescale 1ns/1ps

module revo_timing_checker import revo_pkg::*; (
	input logic        clock,
	input logic        rst_n,
	input logic        clear,
	input logic        revo_detect,
	input revo_count_t revo_count,
	input logic        period_error,
	input logic        locked
);

	// A detect is a single-cycle pulse
	detect_single: assert property (@(posedge clock) disable iff (!rst_n)
		revo_detect |=> !revo_detect)
		else $error("revo_detect high for two cycles");

	// Errors are judged only while tracking
	error_locked: assert property (@(posedge clock) disable iff (!rst_n)
		period_error |-> locked)
		else $error("period_error without locked");

	count_moves: assert property (@(posedge clock) disable iff (!rst_n)
		(revo_count != $past(revo_count)) |-> (revo_detect || $past(clear)))
		else $error("revo_count changed outside a detect or clear");

endmodule

bind revo_decoder revo_timing_checker i_revo_timing_checker (.*);

//--- tb/revo_timing_tb.sv
`timescale 1ns/1ps

module revo_timing_tb import revo_pkg::*;;

	logic         clock = 1'b0;
	logic         rst_n, cfg_write, corrupt;
	cfg_addr_t    cfg_addr;
	cfg_data_t    cfg_data, cfg_rdata;
	logic         line_clk, line_trg, line_clk_in, line_trg_in, revo_detect;
	revo_count_t  revo_count;
	revo_length_t last_period;
	logic [31:0]  lfsr_state = 32'h92f7_164c;
	revo_length_t cur_length = 16'd12;
	divide_t      cur_divide = 8'd4;
	int           drop_count = 0, drops_at_clear = 0, clear_id = 0, seen_clear = 0;
	int           seen_drops = 0, det_total = 0, detects_since = 0;
	int           cycle_count = 0, last_detect_cycle = 0;
	int           exp_spacing;
	revo_count_t  exp_count;
	revo_length_t exp_period;
	logic         exp_error;

	revo_timing_top #(.DEFAULT_REVO_LENGTH(16'd12), .DEFAULT_DIVIDE(8'd4)) i_revo_timing_top (
		.clock(clock), .rst_n(rst_n), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .cfg_rdata(cfg_rdata), .line_clk(line_clk), .line_trg(line_trg),
		.line_clk_in(line_clk_in), .line_trg_in(line_trg_in), .revo_detect(revo_detect),
		.revo_count(revo_count), .last_period(last_period)
	);

	always #5 clock = ~clock;

	// Loopback with the trigger line optionally replaced by the carrier
	always @(posedge clock) begin
		line_clk_in <= line_clk;
		line_trg_in <= corrupt ? line_clk : line_trg;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	// Expected behaviour of the link for a given setting and number of erased marks
	function automatic void reference_model(input revo_length_t len, input divide_t div,
		input int detects, input int drops, output int spacing, output revo_count_t count,
		output revo_length_t period, output logic err);
		spacing = int'(len) * int'(div) * (drops + 1);
		count   = revo_count_t'(detects);
		period  = revo_length_t'(int'(len) * (drops + 1));
		err     = (drops > 0);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_count(input string name, input revo_count_t got, input revo_count_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_period(input string name, input revo_length_t got,
		input revo_length_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// One check set per detect pulse
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (seen_clear != clear_id) begin
			seen_clear    = clear_id;
			detects_since = 0;
			seen_drops    = drop_count;
		end
		if (rst_n && revo_detect) begin
			detects_since = detects_since + 1;
			det_total     = det_total + 1;
			reference_model(cur_length, cur_divide, detects_since, drop_count - seen_drops,
				exp_spacing, exp_count, exp_period, exp_error);
			check_count("revo_count", revo_count, exp_count);
			if (detects_since >= 2) begin
				check_period("last_period", last_period, exp_period);
				if (cycle_count - last_detect_cycle != exp_spacing)
					fail_run($sformatf("revo_detect came %0d cycles after the previous one, not %0d",
						cycle_count - last_detect_cycle, exp_spacing));
			end
			last_detect_cycle = cycle_count;
			seen_drops        = drop_count;
		end
	end

	task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
		@(posedge clock);
		cfg_write <= 1'b1;
		cfg_addr  <= addr;
		cfg_data  <= data;
		@(posedge clock);
		cfg_write <= 1'b0;
	endtask

	task automatic read_check(input cfg_addr_t addr, input cfg_data_t exp, input string name);
		@(posedge clock);
		cfg_addr <= addr;
		@(posedge clock);
		check_data(name, cfg_rdata, exp);
	endtask

	task automatic wait_detects(input int n);
		int target;
		int guard;
		target = det_total + n;
		guard  = 0;
		while (det_total < target) begin
			@(posedge clock);
			guard++;
			if (guard > (n + 2) * int'(cur_length) * int'(cur_divide) + 64)
				fail_run("Timed out waiting for revo_detect");
		end
	endtask

	// Stop, clear and load a new setting; enable only if asked
	task automatic apply_config(input revo_length_t len, input divide_t div, input logic run);
		write_reg(ADDR_CONTROL, 16'h0000);
		repeat (8) @(posedge clock);
		clear_id++;
		write_reg(ADDR_CONTROL, 16'h0002);
		write_reg(ADDR_LENGTH, len);
		write_reg(ADDR_DIVIDE, cfg_data_t'(div));
		cur_length     = len;
		cur_divide     = div;
		drops_at_clear = drop_count;
		if (run)
			write_reg(ADDR_CONTROL, 16'h0001);
	endtask

	task automatic status_check();
		reference_model(cur_length, cur_divide, 0, drop_count - drops_at_clear,
			exp_spacing, exp_count, exp_period, exp_error);
		read_check(ADDR_STATUS, cfg_data_t'({1'b1, exp_error}), "status");
	endtask

	initial begin
		int snapshot;
		revo_length_t rand_length;
		divide_t      rand_divide;
		rst_n = 1'b0;
		cfg_write = 1'b0;
		cfg_addr = ADDR_LENGTH;
		cfg_data = '0;
		corrupt = 1'b0;
		line_clk_in = 1'b0;
		line_trg_in = 1'b0;
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		if ({line_clk, line_trg, revo_detect} !== 3'b000)
			fail_run($sformatf("Mismatch {line_clk, line_trg, revo_detect}: got %h, expected %h",
				{line_clk, line_trg, revo_detect}, 3'b000));
		check_count("revo_count", revo_count, '0);
		check_period("last_period", last_period, '0);
		read_check(ADDR_STATUS, 16'h0000, "status");
		read_check(ADDR_LENGTH, 16'd12, "revo_length");
		read_check(ADDR_DIVIDE, 16'd4, "divide");
		read_check(ADDR_CONTROL, 16'h0000, "control");

		apply_config(16'd12, 8'd4, 1'b1);
		wait_detects(4);
		status_check();

		for (int k = 0; k < 4; k++) begin
			rand_length = revo_length_t'(2 + random_bits(6) % 39);
			rand_divide = divide_t'(2 + random_bits(3));
			apply_config(rand_length, rand_divide, 1'b1);
			wait_detects(4);
			check_period("last_period", last_period, cur_length);
			status_check();
		end

		// Erase one marker while tracking
		apply_config(16'd12, 8'd4, 1'b1);
		wait_detects(3);
		repeat (int'(cur_divide) + 2) @(posedge clock);
		corrupt <= 1'b1;
		drop_count++;
		repeat (int'(cur_length) * int'(cur_divide)) @(posedge clock);
		corrupt <= 1'b0;
		wait_detects(1);
		check_period("last_period", last_period, revo_length_t'(2 * int'(cur_length)));
		status_check();
		wait_detects(1);
		status_check();

		apply_config(16'd12, 8'd4, 1'b0);
		repeat (4) @(posedge clock);
		check_count("revo_count", revo_count, '0);
		check_period("last_period", last_period, '0);
		read_check(ADDR_STATUS, 16'h0000, "status");
		snapshot = det_total;
		repeat (3 * int'(cur_length) * int'(cur_divide)) @(posedge clock);
		if (det_total != snapshot)
			fail_run("revo_detect pulsed while disabled");
		$display("sim passed");
		$finish;
	end

endmodule

//--- revo_timing.f
rtl/revo_pkg.sv
rtl/revo_config_regs.sv
rtl/revo_generator.sv
rtl/revo_encoder.sv
rtl/revo_decoder.sv
rtl/revo_timing_top.sv
tb/revo_timing_checker.sv
tb/revo_timing_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= revo_timing_tb
FILELIST  ?= revo_timing.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
